// ==== src.f ====
+incdir+tests
source/rvPkg.sv
source/controlDecoder.sv
source/immExtend.sv
source/regFile.sv
source/alu.sv
source/hazardUnit.sv
source/riscvPipeline.sv
tests/riscvPipeline_assertions.sv
tests/riscvPipelineTb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, and judge by its output
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module riscvPipelineTb -f src.f

status=0
output=$(./obj_dir/VriscvPipelineTb 2>&1) || status=$?
printf '%s\n' "$output"
echo "simulator exit status $status"

printf '%s\n' "$output" | grep -q "TESTS PASSED"

// ==== tests/isaModel.svh ====
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH
`default_nettype none

// instruction kinds the generator emits and the model executes
typedef enum logic [3:0] {
  opLw, opSw, opAdd, opSub, opAnd, opOr, opSlt,
  opAddi, opAndi, opOri, opSlti, opBeq, opJal
} instrKindT;

// decoded fields kept per word so the model never parses the encoding
instrKindT      progKind [kImemWords];
rvPkg::regAddrT progRd   [kImemWords];
rvPkg::regAddrT progRs1  [kImemWords];
rvPkg::regAddrT progRs2  [kImemWords];
rvPkg::wordT    progImm  [kImemWords];
int             progLen;
// expected stores, in program order
rvPkg::wordT    expAddr [$];
rvPkg::wordT    expData [$];

// every bit of the word index feeds the fill value
function automatic rvPkg::wordT fillWord(input int index);
  return (index * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
endfunction

// encodes one instruction into imem and records its fields
task automatic emit(input instrKindT kind, input int rd, input int rs1, input int rs2,
                    input int imm);
  logic [2:0]  f3;
  logic [6:0]  f7;
  rvPkg::wordT immW;
  rvPkg::wordT word;
  immW = rvPkg::wordT'(imm);
  f7   = (kind == opSub) ? 7'b0100000 : 7'b0000000;
  case (kind)
    opAdd, opSub, opAddi, opBeq: f3 = 3'b000;
    opSlt, opSlti, opLw, opSw:   f3 = 3'b010;
    opOr, opOri:                 f3 = 3'b110;
    default:                     f3 = 3'b111;
  endcase
  case (kind)
    opLw: word = {immW[11:0], 5'(rs1), f3, 5'(rd), rvPkg::load};
    opSw: word = {immW[11:5], 5'(rs2), 5'(rs1), f3, immW[4:0], rvPkg::store};
    opAdd, opSub, opAnd, opOr, opSlt:
      word = {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), rvPkg::rType};
    // b format scatters bits 12 and 11 to the ends
    opBeq:
      word = {immW[12], immW[10:5], 5'(rs2), 5'(rs1), f3, immW[4:1], immW[11],
              rvPkg::branch};
    opJal:
      word = {immW[20], immW[10:1], immW[11], immW[19:12], 5'(rd), rvPkg::jal};
    default: word = {immW[11:0], 5'(rs1), f3, 5'(rd), rvPkg::iType};
  endcase
  imem[progLen]     = word;
  progKind[progLen] = kind;
  progRd[progLen]   = 5'(rd);
  progRs1[progLen]  = 5'(rs1);
  progRs2[progLen]  = 5'(rs2);
  progImm[progLen]  = immW;
  progLen++;
endtask

// random instructions over x0 to x7 so hazards are frequent
task automatic emitRandom(input int count);
  int        pick;
  int        rd;
  int        rs1;
  int        rs2;
  int        imm12;
  int        offset;
  int        hop;
  instrKindT kind;
  for (int n = 0; n < count; n++)
  begin
    pick   = $urandom_range(12, 0);
    kind   = instrKindT'(pick);
    rd     = $urandom_range(7, 0);
    rs1    = $urandom_range(7, 0);
    rs2    = $urandom_range(7, 0);
    imm12  = $urandom_range(4095, 0) - 2048;
    // word aligned below 256, base x0
    offset = $urandom_range(63, 0) * 4;
    // forward by 8, 12 or 16 bytes
    hop    = $urandom_range(4, 2) * 4;
    case (kind)
      opLw:  emit(opLw, rd, 0, 0, offset);
      opSw:  emit(opSw, 0, 0, rs2, offset);
      opBeq: emit(opBeq, 0, rs1, rs2, hop);
      opJal: emit(opJal, rd, 0, 0, hop);
      opAdd, opSub, opAnd, opOr, opSlt: emit(kind, rd, rs1, rs2, 0);
      default: emit(kind, rd, rs1, 0, imm12);
    endcase
  end
endtask

// architectural execution up to the jal x0,0 self-loop
task automatic runModel();
  rvPkg::wordT regs [8];
  rvPkg::wordT mem  [kDmemWords];
  rvPkg::wordT a;
  rvPkg::wordT b;
  rvPkg::wordT imm;
  rvPkg::wordT addr;
  rvPkg::wordT res;
  rvPkg::wordT pc;
  rvPkg::wordT nextPc;
  int          idx;
  for (int i = 0; i < 8; i++)
    regs[i] = '0;
  for (int i = 0; i < kDmemWords; i++)
    mem[i] = fillWord(i);
  pc = '0;
  // forward-only code, so one pass over the program is enough
  for (int step = 0; step < kImemWords; step++)
  begin
    idx = int'(pc[8:2]);
    if (progKind[idx] == opJal && progImm[idx] == '0)
      break;
    a      = regs[progRs1[idx][2:0]];
    b      = regs[progRs2[idx][2:0]];
    imm    = progImm[idx];
    addr   = a + imm;
    res    = '0;
    nextPc = pc + 32'd4;
    case (progKind[idx])
      opAdd:  res = a + b;
      opSub:  res = a - b;
      opAnd:  res = a & b;
      opOr:   res = a | b;
      opSlt:  res = {31'b0, $signed(a) < $signed(b)};
      opAddi: res = a + imm;
      opAndi: res = a & imm;
      opOri:  res = a | imm;
      opSlti: res = {31'b0, $signed(a) < $signed(imm)};
      opLw:   res = mem[addr[8:2]];
      opSw:
      begin
        mem[addr[8:2]] = b;
        expAddr.push_back(addr);
        expData.push_back(b);
      end
      opBeq:
        if (a == b)
          nextPc = pc + imm;
      default:
      begin
        // jal links the next sequential address
        res    = pc + 32'd4;
        nextPc = pc + imm;
      end
    endcase
    if (!(progKind[idx] inside {opSw, opBeq}) && progRd[idx] != '0)
      regs[progRd[idx][2:0]] = res;
    pc = nextPc;
  end
endtask

`default_nettype wire
`endif

// ==== tests/riscvPipelineTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscvPipelineTb;

  localparam int          kImemWords     = 128;
  localparam int          kDmemWords     = 128;
  localparam int          kRandomInstrs  = 48;
  localparam int          kHalfPeriod    = 20;
  localparam int          kResetCycles   = 3;
  localparam int          kTimeoutCycles = 4000;
  localparam int          kQuietCycles   = 20;
  localparam logic [31:0] kSeed          = 32'h9139_1320;

  logic          clk;
  logic          reset;
  rvPkg::wordT   pcF;
  rvPkg::wordT   instrF;
  rvPkg::memReqT dataReq;
  rvPkg::wordT   readData;

  // both memories live here, the core only sees ports
  rvPkg::wordT imem [kImemWords];
  rvPkg::wordT dmem [kDmemWords];
  int          writeCount;
  int          cycles;

  `include "isaModel.svh"

  riscvPipeline DUT (
    .clk      (clk),
    .reset    (reset),
    .pcF      (pcF),
    .instrF   (instrF),
    .dataReq  (dataReq),
    .readData (readData)
  );

  bind riscvPipeline riscvPipelineAssertions assertions (
    .clk     (clk),
    .reset   (reset),
    .pcF     (pcF),
    .stallF  (stallF),
    .stallD  (stallD),
    .dataReq (dataReq)
  );

  // same-cycle memory answers
  assign instrF   = imem[pcF[8:2]];
  assign readData = dmem[dataReq.addr[8:2]];

  initial
  begin
    clk = 1'b0;
    forever #kHalfPeriod clk = ~clk;
  end

  task automatic reportFailure(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic checkWord(input string name, input rvPkg::wordT expected,
                           input rvPkg::wordT actual);
    assert (actual === expected)
    else
      reportFailure($sformatf("mismatch %s: expected %h, actual %h", name, expected, actual));
  endtask

  task automatic checkIdle(input string phase);
    checkWord({"reset state, pcF ", phase}, '0, pcF);
    checkWord({"reset state, write ", phase}, '0, {31'b0, dataReq.write});
  endtask

  // directed prefix, random body, register dump and self-loop
  task automatic buildProgram();
    emit(opAddi, 1, 0, 0, -77);
    // x1 straight from memory stage
    emit(opAddi, 2, 1, 0, 500);
    emit(opAddi, 3, 0, 0, -1024);
    emit(opAdd, 4, 2, 1, 0);
    emit(opSub, 5, 4, 3, 0);
    // both operands negative
    emit(opSlt, 6, 3, 1, 0);
    emit(opOr, 7, 5, 3, 0);
    emit(opAnd, 7, 7, 4, 0);
    emit(opSw, 0, 0, 7, 4);
    emit(opSw, 0, 0, 6, 8);
    // load then direct consumer, one stall
    emit(opLw, 1, 0, 0, 4);
    emit(opAdd, 2, 1, 5, 0);
    emit(opSw, 0, 0, 2, 12);
    emitRandom(kRandomInstrs);
    for (int r = 1; r < 8; r++)
      emit(opSw, 0, 0, r, 256 + 4 * r);
    emit(opJal, 0, 0, 0, 0);
  endtask

  // data memory writes and the store order check
  always @(posedge clk)
  begin
    if (reset)
    begin
      writeCount <= 0;
      for (int i = 0; i < kDmemWords; i++)
        dmem[i] <= fillWord(i);
    end
    else if (dataReq.write)
    begin
      assert (writeCount < expAddr.size())
      else
        reportFailure($sformatf("store of %h to %h after all %0d expected stores",
                                dataReq.wData, dataReq.addr, expAddr.size()));
      checkWord($sformatf("store order, store %0d address", writeCount),
                expAddr[writeCount], dataReq.addr);
      checkWord($sformatf("store order, store %0d data", writeCount),
                expData[writeCount], dataReq.wData);
      dmem[dataReq.addr[8:2]] <= dataReq.wData;
      writeCount <= writeCount + 1;
    end
  end

  initial
  begin
    reset <= 1'b1;
    void'($urandom(kSeed));
    progLen = 0;
    for (int i = 0; i < kImemWords; i++)
      imem[i] = rvPkg::kNop;
    buildProgram();
    runModel();

    repeat (kResetCycles - 1)
    begin
      @(negedge clk);
      checkIdle("during reset");
    end
    @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    checkIdle("after reset");

    cycles = 0;
    while (writeCount < expAddr.size() && cycles < kTimeoutCycles)
    begin
      @(posedge clk);
      cycles++;
    end
    if (writeCount < expAddr.size())
      reportFailure($sformatf("timeout: only %0d of %0d stores seen after %0d cycles",
                              writeCount, expAddr.size(), cycles));
    else
    begin
      // any late store trips the monitor during this window
      repeat (kQuietCycles) @(posedge clk);
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== tests/riscvPipeline_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscvPipelineAssertions (
  input logic          clk,
  input logic          reset,
  input rvPkg::wordT   pcF,
  input logic          stallF,
  input logic          stallD,
  input rvPkg::memReqT dataReq
);

  // a stalled fetch keeps its address
  pcHeldOnStall: assert property (@(posedge clk) disable iff (reset)
    stallF |=> pcF == $past(pcF))
    else $error("pcF changed after a fetch stall");

  // load-use bubble moves the load on, so decode waits one cycle only
  stallOneCycle: assert property (@(posedge clk) disable iff (reset)
    stallD |=> !stallD)
    else $error("decode stall lasted more than one cycle");

  // only word stores exist
  storeAligned: assert property (@(posedge clk) disable iff (reset)
    dataReq.write |-> dataReq.addr[1:0] == 2'b00)
    else $error("store address not word aligned");

  writeKnown: assert property (@(posedge clk) disable iff (reset)
    !$isunknown(dataReq.write))
    else $error("dataReq.write is unknown");

endmodule

`default_nettype wire

// ==== source/riscvPipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscvPipeline (
  input  logic          clk,
  input  logic          reset,
  output rvPkg::wordT   pcF,
  input  rvPkg::wordT   instrF,
  output rvPkg::memReqT dataReq,
  input  rvPkg::wordT   readData
);

  // fetch to decode
  typedef struct packed {
    rvPkg::wordT instr;
    rvPkg::wordT pc;
    rvPkg::wordT pcPlus4;
  } decodeRegT;

  // decode to execute, full control word
  typedef struct packed {
    rvPkg::ctrlT    ctrl;
    rvPkg::wordT    rd1;
    rvPkg::wordT    rd2;
    rvPkg::wordT    imm;
    rvPkg::wordT    pc;
    rvPkg::wordT    pcPlus4;
    rvPkg::regAddrT rs1;
    rvPkg::regAddrT rs2;
    rvPkg::regAddrT rd;
  } executeRegT;

  // branch and alu fields are gone after execute
  typedef struct packed {
    logic             regWrite;
    rvPkg::resultSrcT resultSrc;
    logic             memWrite;
    rvPkg::wordT      aluResult;
    rvPkg::wordT      writeData;
    rvPkg::wordT      pcPlus4;
    rvPkg::regAddrT   rd;
  } memoryRegT;

  typedef struct packed {
    logic             regWrite;
    rvPkg::resultSrcT resultSrc;
    rvPkg::wordT      aluResult;
    rvPkg::wordT      readData;
    rvPkg::wordT      pcPlus4;
    rvPkg::regAddrT   rd;
  } writebackRegT;

  decodeRegT      decodeQ, decodeNext, decodeBubble;
  executeRegT     executeQ;
  memoryRegT      memoryQ;
  writebackRegT   writebackQ;
  rvPkg::wordT    pcPlus4F, pcNextF;
  rvPkg::ctrlT    ctrlD;
  rvPkg::immSrcT  immSrcD;
  rvPkg::wordT    immD, rd1D, rd2D;
  rvPkg::regAddrT rs1D, rs2D, rdD;
  rvPkg::fwdSelT  fwdA, fwdB;
  rvPkg::wordT    srcAE, writeDataE, srcBE, aluResultE, targetE;
  logic           zeroE, pcSrcE, loadE;
  rvPkg::wordT    resultM, resultW;
  logic           stallF, stallD, flushD, flushE;

  // fetch
  assign pcPlus4F = pcF + rvPkg::kPcStep;
  assign pcNextF  = pcSrcE ? targetE : pcPlus4F;

  always_ff @(posedge clk, posedge reset)
    if (reset)
      pcF <= '0;
    else if (!stallF)
      pcF <= pcNextF;

  assign decodeNext   = '{instr: instrF, pc: pcF, pcPlus4: pcPlus4F};
  assign decodeBubble = '{instr: rvPkg::kNop, pc: '0, pcPlus4: '0};

  // flush wins over stall
  always_ff @(posedge clk, posedge reset)
    if (reset)
      decodeQ <= decodeBubble;
    else if (flushD)
      decodeQ <= decodeBubble;
    else if (!stallD)
      decodeQ <= decodeNext;

  // decode
  assign rs1D = decodeQ.instr[19:15];
  assign rs2D = decodeQ.instr[24:20];
  assign rdD  = decodeQ.instr[11:7];

  controlDecoder decoder (.instr(decodeQ.instr), .ctrl(ctrlD), .immSrc(immSrcD));

  immExtend extender (.instr(decodeQ.instr), .immSrc(immSrcD), .imm(immD));

  regFile registers (
    .clk       (clk),
    .writeEn   (writebackQ.regWrite),
    .readAddr1 (rs1D),
    .readAddr2 (rs2D),
    .writeAddr (writebackQ.rd),
    .writeData (resultW),
    .readData1 (rd1D),
    .readData2 (rd2D)
  );

  // a cleared execute register is a bubble
  always_ff @(posedge clk, posedge reset)
    if (reset)
      executeQ <= '0;
    else if (flushE)
      executeQ <= '0;
    else
      executeQ <= '{ctrl: ctrlD, rd1: rd1D, rd2: rd2D, imm: immD, pc: decodeQ.pc,
                    pcPlus4: decodeQ.pcPlus4, rs1: rs1D, rs2: rs2D, rd: rdD};

  // execute operand select after forwarding
  function automatic rvPkg::wordT forwardPick(input rvPkg::fwdSelT sel,
                                              input rvPkg::wordT fromReg);
    case (sel)
      rvPkg::fwdFromM: return resultM;
      rvPkg::fwdFromW: return resultW;
      default:         return fromReg;
    endcase
  endfunction

  always_comb
  begin
    srcAE      = forwardPick(fwdA, executeQ.rd1);
    writeDataE = forwardPick(fwdB, executeQ.rd2);
  end

  assign srcBE = executeQ.ctrl.aluSrc ? executeQ.imm : writeDataE;

  alu alu (.a(srcAE), .b(srcBE), .aluCtrl(executeQ.ctrl.aluCtrl),
           .result(aluResultE), .zero(zeroE));

  // beq and jal share the pc-relative target
  assign targetE = executeQ.pc + executeQ.imm;
  assign pcSrcE  = (executeQ.ctrl.branch & zeroE) | executeQ.ctrl.jump;
  assign loadE   = (executeQ.ctrl.resultSrc == rvPkg::resMem);

  hazardUnit hazards (
    .rs1D      (rs1D),
    .rs2D      (rs2D),
    .rs1E      (executeQ.rs1),
    .rs2E      (executeQ.rs2),
    .rdE       (executeQ.rd),
    .rdM       (memoryQ.rd),
    .rdW       (writebackQ.rd),
    .regWriteM (memoryQ.regWrite),
    .regWriteW (writebackQ.regWrite),
    .loadE     (loadE),
    .pcSrcE    (pcSrcE),
    .fwdA      (fwdA),
    .fwdB      (fwdB),
    .stallF    (stallF),
    .stallD    (stallD),
    .flushD    (flushD),
    .flushE    (flushE)
  );

  // memory
  always_ff @(posedge clk, posedge reset)
    if (reset)
      memoryQ <= '0;
    else
      memoryQ <= '{regWrite: executeQ.ctrl.regWrite, resultSrc: executeQ.ctrl.resultSrc,
                   memWrite: executeQ.ctrl.memWrite, aluResult: aluResultE,
                   writeData: writeDataE, pcPlus4: executeQ.pcPlus4, rd: executeQ.rd};

  assign dataReq = '{addr: memoryQ.aluResult, wData: memoryQ.writeData,
                     write: memoryQ.memWrite};

  // value a jal in memory would forward is its link, not the alu output
  assign resultM = (memoryQ.resultSrc == rvPkg::resPcPlus4) ? memoryQ.pcPlus4
                                                            : memoryQ.aluResult;

  // writeback
  always_ff @(posedge clk, posedge reset)
    if (reset)
      writebackQ <= '0;
    else
      writebackQ <= '{regWrite: memoryQ.regWrite, resultSrc: memoryQ.resultSrc,
                      aluResult: memoryQ.aluResult, readData: readData,
                      pcPlus4: memoryQ.pcPlus4, rd: memoryQ.rd};

  always_comb
  begin
    case (writebackQ.resultSrc)
      rvPkg::resMem:     resultW = writebackQ.readData;
      rvPkg::resPcPlus4: resultW = writebackQ.pcPlus4;
      default:           resultW = writebackQ.aluResult;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/hazardUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
  input  rvPkg::regAddrT rs1D,
  input  rvPkg::regAddrT rs2D,
  input  rvPkg::regAddrT rs1E,
  input  rvPkg::regAddrT rs2E,
  input  rvPkg::regAddrT rdE,
  input  rvPkg::regAddrT rdM,
  input  rvPkg::regAddrT rdW,
  input  logic           regWriteM,
  input  logic           regWriteW,
  input  logic           loadE,
  input  logic           pcSrcE,
  output rvPkg::fwdSelT  fwdA,
  output rvPkg::fwdSelT  fwdB,
  output logic           stallF,
  output logic           stallD,
  output logic           flushD,
  output logic           flushE
);

  logic loadStall;

  // youngest producer wins, x0 never forwards
  function automatic rvPkg::fwdSelT pickSource(input rvPkg::regAddrT src);
    if (src == '0)
      return rvPkg::fwdNone;
    else if (regWriteM && src == rdM)
      return rvPkg::fwdFromM;
    else if (regWriteW && src == rdW)
      return rvPkg::fwdFromW;
    else
      return rvPkg::fwdNone;
  endfunction

  always_comb
  begin
    fwdA = pickSource(rs1E);
    fwdB = pickSource(rs2E);
  end

  // load data only exists in memory, so a direct consumer waits a cycle
  assign loadStall = loadE && rdE != '0 && (rdE == rs1D || rdE == rs2D);

  assign stallF = loadStall;
  assign stallD = loadStall;
  // taken branch or jump kills the two younger instructions
  assign flushD = pcSrcE;
  assign flushE = pcSrcE | loadStall;

endmodule

`default_nettype wire

// ==== source/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  rvPkg::wordT    a,
  input  rvPkg::wordT    b,
  input  rvPkg::aluCtrlT aluCtrl,
  output rvPkg::wordT    result,
  output logic           zero
);

  rvPkg::wordT bMaybeInv;
  rvPkg::wordT sum;
  logic        subtract;
  logic        overflow;

  // sub and slt share the adder with b inverted plus carry in
  assign subtract  = aluCtrl[0];
  assign bMaybeInv = subtract ? ~b : b;
  assign sum       = a + bMaybeInv + rvPkg::wordT'(subtract);

  // signed overflow of a +/- b
  assign overflow = ~(subtract ^ a[31] ^ b[31]) & (a[31] ^ sum[31]);

  always_comb
  begin
    case (aluCtrl)
      rvPkg::aluAdd: result = sum;
      rvPkg::aluSub: result = sum;
      rvPkg::aluAnd: result = a & b;
      rvPkg::aluOr:  result = a | b;
      // true sign of a - b
      rvPkg::aluSlt: result = {31'b0, sum[31] ^ overflow};
      default:       result = sum;
    endcase
  end

  assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== source/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile (
  input  logic           clk,
  input  logic           writeEn,
  input  rvPkg::regAddrT readAddr1,
  input  rvPkg::regAddrT readAddr2,
  input  rvPkg::regAddrT writeAddr,
  input  rvPkg::wordT    writeData,
  output rvPkg::wordT    readData1,
  output rvPkg::wordT    readData2
);

  // x0 has no storage
  rvPkg::wordT regs [31:1];

  always_ff @(posedge clk)
    if (writeEn && writeAddr != '0)
      regs[writeAddr] <= writeData;

  // write-through so decode sees the value writeback commits this cycle
  function automatic rvPkg::wordT readPort(input rvPkg::regAddrT addr);
    if (addr == '0)
      return '0;
    else if (writeEn && addr == writeAddr)
      return writeData;
    else
      return regs[addr];
  endfunction

  always_comb
  begin
    readData1 = readPort(readAddr1);
    readData2 = readPort(readAddr2);
  end

endmodule

`default_nettype wire

// ==== source/immExtend.sv ====
`timescale 1ns/1ps
`default_nettype none

module immExtend (
  input  rvPkg::wordT   instr,
  input  rvPkg::immSrcT immSrc,
  output rvPkg::wordT   imm
);

  always_comb
  begin
    case (immSrc)
      // lw and alu immediates
      rvPkg::immI: imm = {{20{instr[31]}}, instr[31:20]};
      // store offset split around rs2
      rvPkg::immS: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      // branch offset in halfwords
      rvPkg::immB: imm = {{20{instr[31]}}, instr[7], instr[30:25],
                          instr[11:8], 1'b0};
      // jal offset, 21 bits after the zero lsb
      rvPkg::immJ: imm = {{12{instr[31]}}, instr[19:12], instr[20],
                          instr[30:21], 1'b0};
      default:     imm = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/controlDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlDecoder (
  input  rvPkg::wordT   instr,
  output rvPkg::ctrlT   ctrl,
  output rvPkg::immSrcT immSrc
);

  rvPkg::opcodeT op;
  logic [2:0]    funct3;
  logic          rTypeSub;
  logic          aluFromFunct;

  assign op     = rvPkg::opcodeT'(instr[6:0]);
  assign funct3 = instr[14:12];
  // funct7 bit 30 only means subtract for register-register ops
  assign rTypeSub = instr[30] & instr[5];

  always_comb
  begin
    // unknown opcodes fall through as bubbles
    ctrl         = '0;
    immSrc       = rvPkg::immI;
    aluFromFunct = 1'b0;
    case (op)
      rvPkg::load:
      begin
        ctrl.regWrite  = 1'b1;
        ctrl.aluSrc    = 1'b1;
        ctrl.resultSrc = rvPkg::resMem;
      end
      rvPkg::store:
      begin
        immSrc        = rvPkg::immS;
        ctrl.aluSrc   = 1'b1;
        ctrl.memWrite = 1'b1;
      end
      rvPkg::rType:
      begin
        ctrl.regWrite = 1'b1;
        aluFromFunct  = 1'b1;
      end
      rvPkg::iType:
      begin
        ctrl.regWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
        aluFromFunct  = 1'b1;
      end
      rvPkg::branch:
      begin
        immSrc      = rvPkg::immB;
        ctrl.branch = 1'b1;
      end
      rvPkg::jal:
      begin
        immSrc         = rvPkg::immJ;
        ctrl.regWrite  = 1'b1;
        ctrl.jump      = 1'b1;
        ctrl.resultSrc = rvPkg::resPcPlus4;
      end
      default: ;
    endcase

    // alu decode, beq compares by subtracting
    if (ctrl.branch)
      ctrl.aluCtrl = rvPkg::aluSub;
    else if (aluFromFunct)
      case (funct3)
        3'b000:  ctrl.aluCtrl = rTypeSub ? rvPkg::aluSub : rvPkg::aluAdd;
        3'b010:  ctrl.aluCtrl = rvPkg::aluSlt;
        3'b110:  ctrl.aluCtrl = rvPkg::aluOr;
        3'b111:  ctrl.aluCtrl = rvPkg::aluAnd;
        default: ctrl.aluCtrl = rvPkg::aluAdd;
      endcase
    else
      // address calc for lw and sw
      ctrl.aluCtrl = rvPkg::aluAdd;
  end

endmodule

`default_nettype wire

// ==== source/rvPkg.sv ====
`default_nettype none

package rvPkg;

  // data word, pc and instruction width
  typedef logic [31:0] wordT;

  // register index
  typedef logic [4:0] regAddrT;

  // addi x0, x0, 0 is the canonical bubble in decode
  localparam wordT kNop = 32'h0000_0013;

  // sequential fetch increment
  localparam wordT kPcStep = 32'd4;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    load   = 7'b0000011,
    store  = 7'b0100011,
    rType  = 7'b0110011,
    iType  = 7'b0010011,
    branch = 7'b1100011,
    jal    = 7'b1101111
  } opcodeT;

  // bit 0 set means the adder subtracts, slt relies on that
  typedef enum logic [2:0] {
    aluAdd = 3'b000,
    aluSub = 3'b001,
    aluAnd = 3'b010,
    aluOr  = 3'b011,
    aluSlt = 3'b101
  } aluCtrlT;

  typedef enum logic [1:0] {
    immI = 2'b00,
    immS = 2'b01,
    immB = 2'b10,
    immJ = 2'b11
  } immSrcT;

  // writeback source
  typedef enum logic [1:0] {
    resAlu     = 2'b00,
    resMem     = 2'b01,
    resPcPlus4 = 2'b10
  } resultSrcT;

  // operand source in execute
  typedef enum logic [1:0] {
    fwdNone  = 2'b00,
    fwdFromW = 2'b01,
    fwdFromM = 2'b10
  } fwdSelT;

  // decoded control, all zero is a bubble
  typedef struct packed {
    logic      regWrite;
    resultSrcT resultSrc;
    logic      memWrite;
    logic      branch;
    logic      jump;
    logic      aluSrc;
    aluCtrlT   aluCtrl;
  } ctrlT;

  // data port request from the memory stage
  typedef struct packed {
    wordT addr;
    wordT wData;
    logic write;
  } memReqT;

endpackage

`default_nettype wire
